//--- src.f
+incdir+design
design/lcd_bus_pkg.sv
design/lcd_cmd_pkg.sv
design/lcd_init_seq.sv
design/lcd_draw_engine.sv
design/lcd_bus_writer.sv
design/lcd_top.sv
test/lcd_panel_model.sv
test/lcd_tb.sv

//--- Makefile
# Verilator build and run of the lcd controller testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run lcd_tb, check sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --top-module lcd_tb -f src.f -o Vlcd_tb
	./obj_dir/Vlcd_tb > sim.log 2>&1; cat sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/lcd_tb.sv
// testbench for the lcd controller with init replay, random fills and backlight commands
module lcd_tb
    import lcd_bus_pkg::*;
    import lcd_cmd_pkg::*;
();

    // guard already set when the sequencer pulled the table in
    `undef LCD_INIT_TABLE_SVH
    `include "lcd_init_table.svh"

    localparam int RST_HOLD = 6;
    localparam int RST_WAIT = 4;
    localparam int WR_LOW   = 2;
    localparam int WR_HIGH  = 1;
    localparam int TIMEOUT  = 2000;  // cycles per wait
    localparam logic [31:0] SEED = 32'h9f41_6c33;

    logic      pclk = 1'b0;
    logic      rst_n;
    logic      cmd_stb_i;
    host_op_e  cmd_op_i;
    coord_t    cmd_x0_i, cmd_y0_i, cmd_x1_i, cmd_y1_i;
    lcd_word_t cmd_color_i;
    logic      ready_o, busy_o, done_o, lcd_rst_o, lcd_cs_o, lcd_wr_o, lcd_bl_o;
    lcd_rs_e   lcd_rs_o;
    lcd_word_t lcd_data_o;
    logic      cmd_accept, rect_valid;
    int        err_cnt = 0;
    int        done_cnt = 0;
    int        rst_low_cnt;
    bit        timed_out = 1'b0;

    always #2 pclk = ~pclk;

    lcd_top #(.RST_HOLD(RST_HOLD), .RST_WAIT(RST_WAIT), .WR_LOW(WR_LOW), .WR_HIGH(WR_HIGH)) dut0 (
        .pclk(pclk), .rst_n(rst_n), .cmd_stb_i(cmd_stb_i), .cmd_op_i(cmd_op_i),
        .cmd_x0_i(cmd_x0_i), .cmd_y0_i(cmd_y0_i), .cmd_x1_i(cmd_x1_i), .cmd_y1_i(cmd_y1_i),
        .cmd_color_i(cmd_color_i), .ready_o(ready_o), .busy_o(busy_o), .done_o(done_o),
        .lcd_rst_o(lcd_rst_o), .lcd_cs_o(lcd_cs_o), .lcd_rs_o(lcd_rs_o), .lcd_wr_o(lcd_wr_o),
        .lcd_data_o(lcd_data_o), .lcd_bl_o(lcd_bl_o)
    );

    lcd_panel_model #(.WR_LOW(WR_LOW)) panel0 (
        .pclk(pclk), .rst_n(rst_n), .lcd_cs_i(lcd_cs_o), .lcd_wr_i(lcd_wr_o),
        .lcd_rs_i(lcd_rs_o), .lcd_data_i(lcd_data_o)
    );

    assign cmd_accept = cmd_stb_i && ready_o && !busy_o;
    assign rect_valid = (cmd_x0_i <= cmd_x1_i) && (int'(cmd_x1_i) < SCREEN_W)
                     && (cmd_y0_i <= cmd_y1_i) && (int'(cmd_y1_i) < SCREEN_H);

    always @(posedge pclk) begin
        if (!rst_n) rst_low_cnt <= 0;
        else if (!lcd_rst_o) rst_low_cnt <= rst_low_cnt + 1;
        if (rst_n && done_o) done_cnt <= done_cnt + 1;
    end

    function automatic void log_error(string msg);
        err_cnt++;
        $display("[ERROR] %0t: %s", $time, msg);
    endfunction

    a_reset_idle: assert property (@(posedge pclk)
        !rst_n |=> (lcd_cs_o && lcd_wr_o && !lcd_rst_o && !ready_o && !busy_o && !done_o
                    && !lcd_bl_o)
    ) else log_error("outputs not idle after reset");

    a_rst_hold: assert property (@(posedge pclk) disable iff (!rst_n)
        $rose(lcd_rst_o) |-> (rst_low_cnt == RST_HOLD)
    ) else log_error("panel reset pulse has the wrong length");

    a_bl_on: assert property (@(posedge pclk) disable iff (!rst_n)
        (cmd_accept && cmd_op_i == OP_BL_ON) |=> lcd_bl_o
    ) else log_error("backlight did not turn on");

    a_bl_off: assert property (@(posedge pclk) disable iff (!rst_n)
        (cmd_accept && cmd_op_i == OP_BL_OFF) |=> !lcd_bl_o
    ) else log_error("backlight did not turn off");

    a_bl_busy: assert property (@(posedge pclk) disable iff (!rst_n)
        (cmd_stb_i && busy_o) |=> $stable(lcd_bl_o)
    ) else log_error("backlight changed by a command given while busy");

    a_bad_rect: assert property (@(posedge pclk) disable iff (!rst_n)
        (cmd_accept && cmd_op_i == OP_FILL_RECT && !rect_valid) |=> !busy_o
    ) else log_error("invalid rectangle started a fill");

    task automatic report_timeout(string what);
        timed_out = 1'b1;
        $display("timeout: gave up waiting for %s after %0d cycles", what, TIMEOUT);
    endtask

    task automatic step();  // next edge plus the drive delay
        @(posedge pclk);
        #1;
    endtask

    task automatic wait_ready();
        for (int n = 0; n < TIMEOUT && !ready_o; n++)
            step();
        if (!ready_o) report_timeout("ready_o to rise");
    endtask

    task automatic wait_done();
        for (int n = 0; n < TIMEOUT && !done_o; n++)
            step();
        if (!done_o) report_timeout("done_o after a fill");
    endtask

    task automatic send_cmd(host_op_e op, int x0, int y0, int x1, int y1, lcd_word_t color);
        cmd_op_i    = op;
        cmd_x0_i    = coord_t'(x0);
        cmd_y0_i    = coord_t'(y0);
        cmd_x1_i    = coord_t'(x1);
        cmd_y1_i    = coord_t'(y1);
        cmd_color_i = color;
        cmd_stb_i   = 1'b1;
        step();
        cmd_stb_i   = 1'b0;
    endtask

    // expected k-th bus word of a fill with the header ahead of the colour words
    function automatic logic [16:0] fill_word(int k, int x0, int y0, int x1, int y1,
                                              lcd_word_t color);
        case (k)
            0:       return {RS_CMD, CMD_COL_SET};
            1:       return {RS_DATA, 16'(x0 >> 8)};
            2:       return {RS_DATA, 16'(x0 & 255)};
            3:       return {RS_DATA, 16'(x1 >> 8)};
            4:       return {RS_DATA, 16'(x1 & 255)};
            5:       return {RS_CMD, CMD_PAGE_SET};
            6:       return {RS_DATA, 16'(y0 >> 8)};
            7:       return {RS_DATA, 16'(y0 & 255)};
            8:       return {RS_DATA, 16'(y1 >> 8)};
            9:       return {RS_DATA, 16'(y1 & 255)};
            10:      return {RS_CMD, CMD_MEM_WRITE};
            default: return {RS_DATA, color};
        endcase
    endfunction

    task automatic check_init_words();
        logic [16:0] got;
        assert (panel0.words.size() == INIT_LEN)
            else log_error($sformatf("%0d init words, expected %0d",
                                     panel0.words.size(), INIT_LEN));
        for (int i = 0; i < INIT_LEN && panel0.words.size() > 0; i++) begin
            got = panel0.words.pop_front();
            assert (got == init_table[i])
                else log_error($sformatf("init word %0d is %h, expected %h",
                                         i, got, init_table[i]));
        end
        panel0.words.delete();
    endtask

    task automatic run_fill(int x0, int y0, int x1, int y1, lcd_word_t color, bit poke_bl);
        int          start_done;
        int          total;
        logic [16:0] got;
        logic [16:0] exp_word;
        start_done = done_cnt;
        total      = 11 + (x1 - x0 + 1) * (y1 - y0 + 1);
        send_cmd(OP_FILL_RECT, x0, y0, x1, y1, color);
        if (poke_bl) send_cmd(OP_BL_OFF, 0, 0, 0, 0, '0);  // lands while busy
        wait_done();
        if (timed_out) return;
        step();
        step();  // room for a stray second done pulse
        assert (done_cnt == start_done + 1 && !busy_o)
            else log_error($sformatf("%0d done pulses, busy %b", done_cnt - start_done, busy_o));
        assert (panel0.words.size() == total)
            else log_error($sformatf("fill sent %0d words, expected %0d",
                                     panel0.words.size(), total));
        for (int k = 0; k < total && panel0.words.size() > 0; k++) begin
            got      = panel0.words.pop_front();
            exp_word = fill_word(k, x0, y0, x1, y1, color);
            assert (got == exp_word)
                else log_error($sformatf("fill word %0d is %h, expected %h", k, got, exp_word));
        end
        panel0.words.delete();
    endtask

    task automatic run_bad_rect(int x0, int y0, int x1, int y1);
        int start_done;
        start_done = done_cnt;
        send_cmd(OP_FILL_RECT, x0, y0, x1, y1, 16'hffff);
        repeat (20) step();  // a fill would have shown words by now
        assert (panel0.words.size() == 0 && done_cnt == start_done && !busy_o)
            else log_error($sformatf("invalid rectangle %0d,%0d..%0d,%0d not ignored",
                                     x0, y0, x1, y1));
    endtask

    // init replay, random fills, then invalid rectangles and backlight off
    task automatic drive_all_cases();
        int w;
        int h;
        int x0;
        int y0;
        wait_ready();
        if (timed_out) return;
        check_init_words();
        send_cmd(OP_BL_ON, 0, 0, 0, 0, '0);

        for (int i = 0; i < 8 && !timed_out; i++) begin
            w  = $urandom_range(1, 6);
            h  = $urandom_range(1, 6);
            x0 = $urandom_range(0, SCREEN_W - w);
            y0 = $urandom_range(0, SCREEN_H - h);
            run_fill(x0, y0, x0 + w - 1, y0 + h - 1, 16'($urandom), i == 0);
        end
        if (timed_out) return;
        assert (lcd_bl_o) else log_error("backlight lost during the fills");

        run_bad_rect(3, 0, 2, 0);        // x0 past x1
        run_bad_rect(470, 10, 480, 12);  // right edge
        run_bad_rect(0, 795, 4, 800);    // bottom edge
        send_cmd(OP_BL_OFF, 0, 0, 0, 0, '0);
        step();
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n       = 1'b0;
        cmd_stb_i   = 1'b0;
        cmd_op_i    = OP_FILL_RECT;
        cmd_x0_i    = '0;
        cmd_y0_i    = '0;
        cmd_x1_i    = '0;
        cmd_y1_i    = '0;
        cmd_color_i = '0;
        repeat (2) @(posedge pclk);
        #1;
        rst_n = 1'b1;

        drive_all_cases();

        $display("errors: testbench %0d, panel model %0d", err_cnt, panel0.err_cnt);
        if (!timed_out && err_cnt + panel0.err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- test/lcd_panel_model.sv
// panel model that records every written word and checks the 8080 write timing
module lcd_panel_model
    import lcd_bus_pkg::*;
#(
    parameter int WR_LOW = 2
) (
    input logic      pclk,
    input logic      rst_n,
    input logic      lcd_cs_i,
    input logic      lcd_wr_i,
    input lcd_rs_e   lcd_rs_i,
    input lcd_word_t lcd_data_i
);

    logic [16:0] words[$];  // {rs, data} in bus order
    int          err_cnt = 0;
    int          low_run;   // consecutive cycles with wr low
    logic        wr_q;

    function automatic void log_error(string msg);
        err_cnt++;
        $display("[ERROR] %0t: %s", $time, msg);
    endfunction

    // the panel latches rs and data on the rising wr edge
    always @(posedge pclk) begin
        if (!rst_n) begin
            wr_q    <= 1'b1;
            low_run <= 0;
        end else begin
            wr_q    <= lcd_wr_i;
            low_run <= lcd_wr_i ? 0 : low_run + 1;
            if (!wr_q && lcd_wr_i && !lcd_cs_i) begin
                words.push_back({lcd_rs_i, lcd_data_i});
            end
        end
    end

    a_wr_low_width: assert property (
        @(posedge pclk) disable iff (!rst_n)
        $rose(lcd_wr_i) |-> (low_run == WR_LOW)
    ) else log_error("wr low phase has the wrong width");

    // wr may only pulse inside a chip select window
    a_wr_inside_cs: assert property (
        @(posedge pclk) disable iff (!rst_n)
        !lcd_wr_i |-> !lcd_cs_i
    ) else log_error("wr low while cs is high");

    // a new word may appear only together with the falling wr edge
    a_word_stable: assert property (
        @(posedge pclk) disable iff (!rst_n)
        (!lcd_cs_i && !$fell(lcd_wr_i)) |-> ($stable(lcd_data_i) && $stable(lcd_rs_i))
    ) else log_error("rs or data changed during a write cycle");

endmodule

//--- design/lcd_top.sv
// lcd controller top that joins the init sequencer, draw engine and bus writer
module lcd_top
    import lcd_bus_pkg::*;
    import lcd_cmd_pkg::*;
#(
    parameter int RST_HOLD = 1000,
    parameter int RST_WAIT = 5000,
    parameter int WR_LOW   = 2,
    parameter int WR_HIGH  = 2
) (
    input  logic      pclk,
    input  logic      rst_n,
    input  logic      cmd_stb_i,
    input  host_op_e  cmd_op_i,
    input  coord_t    cmd_x0_i,
    input  coord_t    cmd_y0_i,
    input  coord_t    cmd_x1_i,
    input  coord_t    cmd_y1_i,
    input  lcd_word_t cmd_color_i,
    output logic      ready_o,
    output logic      busy_o,
    output logic      done_o,
    output logic      lcd_rst_o,
    output logic      lcd_cs_o,
    output lcd_rs_e   lcd_rs_o,
    output logic      lcd_wr_o,
    output lcd_word_t lcd_data_o,
    output logic      lcd_bl_o
);

    logic      init_done;
    logic      init_stb, init_ack;   // init channel
    lcd_rs_e   init_rs;
    lcd_word_t init_data;
    logic      draw_stb, draw_ack;   // draw channel
    lcd_rs_e   draw_rs;
    lcd_word_t draw_data;

    lcd_init_seq #(.RST_HOLD(RST_HOLD), .RST_WAIT(RST_WAIT)) u_init_seq (
        .pclk(pclk), .rst_n(rst_n), .init_ack_i(init_ack), .lcd_rst_o(lcd_rst_o),
        .init_stb_o(init_stb), .init_rs_o(init_rs), .init_data_o(init_data),
        .init_done_o(init_done)
    );

    lcd_draw_engine u_draw_engine (
        .pclk(pclk), .rst_n(rst_n), .init_done_i(init_done),
        .cmd_stb_i(cmd_stb_i), .cmd_op_i(cmd_op_i),
        .cmd_x0_i(cmd_x0_i), .cmd_y0_i(cmd_y0_i), .cmd_x1_i(cmd_x1_i), .cmd_y1_i(cmd_y1_i),
        .cmd_color_i(cmd_color_i), .draw_ack_i(draw_ack), .draw_stb_o(draw_stb),
        .draw_rs_o(draw_rs), .draw_data_o(draw_data), .ready_o(ready_o),
        .busy_o(busy_o), .done_o(done_o), .lcd_bl_o(lcd_bl_o)
    );

    lcd_bus_writer #(.WR_LOW(WR_LOW), .WR_HIGH(WR_HIGH)) u_bus_writer (
        .pclk(pclk), .rst_n(rst_n), .init_done_i(init_done),
        .init_stb_i(init_stb), .init_rs_i(init_rs), .init_data_i(init_data),
        .init_ack_o(init_ack),
        .draw_stb_i(draw_stb), .draw_rs_i(draw_rs), .draw_data_i(draw_data),
        .draw_ack_o(draw_ack),
        .lcd_cs_o(lcd_cs_o), .lcd_rs_o(lcd_rs_o), .lcd_wr_o(lcd_wr_o), .lcd_data_o(lcd_data_o)
    );

endmodule

//--- design/lcd_bus_writer.sv
// 8080 bus writer that serves the init or draw channel and shapes each write cycle
module lcd_bus_writer
    import lcd_bus_pkg::*;
#(
    parameter int WR_LOW  = 2,
    parameter int WR_HIGH = 2
) (
    input  logic      pclk,
    input  logic      rst_n,
    input  logic      init_done_i,
    input  logic      init_stb_i,
    input  lcd_rs_e   init_rs_i,
    input  lcd_word_t init_data_i,
    output logic      init_ack_o,
    input  logic      draw_stb_i,
    input  lcd_rs_e   draw_rs_i,
    input  lcd_word_t draw_data_i,
    output logic      draw_ack_o,
    output logic      lcd_cs_o,
    output lcd_rs_e   lcd_rs_o,
    output logic      lcd_wr_o,
    output lcd_word_t lcd_data_o
);

    localparam int PH_MAX = (WR_LOW > WR_HIGH) ? WR_LOW : WR_HIGH;
    localparam int PH_W   = $clog2(PH_MAX + 1);

    bus_state_e      state;
    logic [PH_W-1:0] ph_cnt;
    logic            owner_draw;  // channel of the word on the pins
    logic            sel_stb;
    lcd_rs_e         sel_rs;
    lcd_word_t       sel_data;
    logic            last_ph;
    logic            start;

    // init owns the bus until the table is through
    assign sel_stb  = init_done_i ? draw_stb_i  : init_stb_i;
    assign sel_rs   = init_done_i ? draw_rs_i   : init_rs_i;
    assign sel_data = init_done_i ? draw_data_i : init_data_i;

    assign last_ph    = (state == BUS_WR_HIGH) && (ph_cnt == PH_W'(WR_HIGH - 1));
    assign start      = sel_stb && ((state == BUS_IDLE) || last_ph);
    assign init_ack_o = last_ph && !owner_draw;
    assign draw_ack_o = last_ph && owner_draw;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state      <= BUS_IDLE;
            ph_cnt     <= '0;
            owner_draw <= 1'b0;
            lcd_cs_o   <= STROBE_OFF;
            lcd_wr_o   <= STROBE_OFF;
        end else if (start) begin
            state      <= BUS_WR_LOW;
            ph_cnt     <= '0;
            owner_draw <= init_done_i;
            lcd_cs_o   <= STROBE_ON;
            lcd_wr_o   <= STROBE_ON;
        end else begin
            case (state)
                BUS_WR_LOW: begin
                    if (ph_cnt == PH_W'(WR_LOW - 1)) begin
                        ph_cnt   <= '0;
                        lcd_wr_o <= STROBE_OFF;  // rising edge latches the word
                        state    <= BUS_WR_HIGH;
                    end else begin
                        ph_cnt <= ph_cnt + 1'b1;
                    end
                end
                BUS_WR_HIGH: begin
                    if (last_ph) begin
                        lcd_cs_o <= STROBE_OFF;
                        state    <= BUS_IDLE;
                    end else begin
                        ph_cnt <= ph_cnt + 1'b1;
                    end
                end
                default: ;  // idle until a strobe
            endcase
        end
    end

    // word and rs held on the pins for the whole cycle
    always_ff @(posedge pclk) begin
        if (start) begin
            lcd_rs_o   <= sel_rs;
            lcd_data_o <= sel_data;
        end
    end

    // sources keep one word in flight at most
    a_stb_when_free: assert property (
        @(posedge pclk) disable iff (!rst_n)
        sel_stb |-> ((state == BUS_IDLE) || last_ph)
    ) else $error("strobe while a write cycle is running");

endmodule

//--- design/lcd_draw_engine.sv
// drawing engine that decodes host commands, sequences rectangle fills and holds the backlight
module lcd_draw_engine
    import lcd_bus_pkg::*;
    import lcd_cmd_pkg::*;
(
    input  logic      pclk,
    input  logic      rst_n,
    input  logic      init_done_i,
    input  logic      cmd_stb_i,
    input  host_op_e  cmd_op_i,
    input  coord_t    cmd_x0_i,
    input  coord_t    cmd_y0_i,
    input  coord_t    cmd_x1_i,
    input  coord_t    cmd_y1_i,
    input  lcd_word_t cmd_color_i,
    input  logic      draw_ack_i,
    output logic      draw_stb_o,
    output lcd_rs_e   draw_rs_o,
    output lcd_word_t draw_data_o,
    output logic      ready_o,
    output logic      busy_o,
    output logic      done_o,
    output logic      lcd_bl_o
);

    typedef enum logic [1:0] {
        D_IDLE,
        D_HEADER,
        D_PIXELS
    } draw_state_e;

    draw_state_e state;
    logic [3:0]  hdr_idx;
    pix_cnt_t    pix_left;
    logic        pend;  // word strobed, ack not yet seen
    logic        accept;
    logic        rect_ok;
    pix_cnt_t    rect_w;
    pix_cnt_t    rect_h;
    coord_t      x0_q, x1_q, y0_q, y1_q;
    lcd_word_t   color_q;

    function automatic lcd_word_t coord_hi(input coord_t c);
        return lcd_word_t'(c[9:8]);
    endfunction

    function automatic lcd_word_t coord_lo(input coord_t c);
        return lcd_word_t'(c[7:0]);
    endfunction

    assign ready_o = init_done_i;
    assign busy_o  = (state != D_IDLE);
    assign accept  = cmd_stb_i && init_done_i && (state == D_IDLE);
    assign rect_ok = (cmd_x0_i <= cmd_x1_i) && (cmd_x1_i < coord_t'(SCREEN_W))
                  && (cmd_y0_i <= cmd_y1_i) && (cmd_y1_i < coord_t'(SCREEN_H));
    assign rect_w  = pix_cnt_t'(cmd_x1_i - cmd_x0_i) + 1'b1;
    assign rect_h  = pix_cnt_t'(cmd_y1_i - cmd_y0_i) + 1'b1;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state      <= D_IDLE;
            hdr_idx    <= '0;
            pix_left   <= '0;
            pend       <= 1'b0;
            draw_stb_o <= 1'b0;
            done_o     <= 1'b0;
            lcd_bl_o   <= 1'b0;
        end else begin
            draw_stb_o <= 1'b0;
            done_o     <= 1'b0;
            if (draw_stb_o) pend <= 1'b1;
            if (draw_ack_i) pend <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (accept) begin
                        case (cmd_op_i)
                            OP_FILL_RECT: begin
                                if (rect_ok) begin
                                    hdr_idx    <= '0;
                                    pix_left   <= rect_w * rect_h;
                                    draw_stb_o <= 1'b1;
                                    state      <= D_HEADER;
                                end
                            end
                            OP_BL_ON:  lcd_bl_o <= 1'b1;
                            OP_BL_OFF: lcd_bl_o <= 1'b0;
                            default: ;  // unknown opcode dropped
                        endcase
                    end
                end
                D_HEADER: begin
                    if (draw_ack_i) begin
                        draw_stb_o <= 1'b1;
                        if (hdr_idx == 4'(HDR_MEM_IDX)) state <= D_PIXELS;
                        else hdr_idx <= hdr_idx + 1'b1;
                    end
                end
                D_PIXELS: begin
                    if (draw_ack_i) begin
                        if (pix_left == pix_cnt_t'(1)) begin
                            done_o <= 1'b1;
                            state  <= D_IDLE;
                        end else begin
                            pix_left   <= pix_left - 1'b1;
                            draw_stb_o <= 1'b1;
                        end
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    // rectangle is captured once per fill
    always_ff @(posedge pclk) begin
        if (accept && rect_ok) begin
            x0_q    <= cmd_x0_i;
            x1_q    <= cmd_x1_i;
            y0_q    <= cmd_y0_i;
            y1_q    <= cmd_y1_i;
            color_q <= cmd_color_i;
        end
    end

    always_comb begin
        draw_rs_o   = RS_DATA;
        draw_data_o = color_q;
        if (state == D_HEADER) begin
            case (hdr_idx)
                4'd0:    draw_data_o = CMD_COL_SET;
                4'd1:    draw_data_o = coord_hi(x0_q);
                4'd2:    draw_data_o = coord_lo(x0_q);
                4'd3:    draw_data_o = coord_hi(x1_q);
                4'd4:    draw_data_o = coord_lo(x1_q);
                4'd5:    draw_data_o = CMD_PAGE_SET;
                4'd6:    draw_data_o = coord_hi(y0_q);
                4'd7:    draw_data_o = coord_lo(y0_q);
                4'd8:    draw_data_o = coord_hi(y1_q);
                4'd9:    draw_data_o = coord_lo(y1_q);
                default: draw_data_o = CMD_MEM_WRITE;
            endcase
            if (hdr_idx == 4'(HDR_COL_IDX) || hdr_idx == 4'(HDR_PAGE_IDX)
                    || hdr_idx == 4'(HDR_MEM_IDX)) begin
                draw_rs_o = RS_CMD;
            end
        end else if (state == D_IDLE) begin
            draw_data_o = LCD_WORD_IDLE;
        end
    end

    a_ack_needs_pending: assert property (
        @(posedge pclk) disable iff (!rst_n)
        draw_ack_i |-> pend
    ) else $error("draw ack with no word outstanding");

    a_done_ends_busy: assert property (
        @(posedge pclk) disable iff (!rst_n)
        done_o |-> $past(busy_o)
    ) else $error("done pulse without a fill in progress");

endmodule

//--- design/lcd_init_seq.sv
// panel init sequencer that pulses the panel reset and sends the init table
module lcd_init_seq
    import lcd_bus_pkg::*;
#(
    parameter int RST_HOLD = 1000,
    parameter int RST_WAIT = 5000
) (
    input  logic      pclk,
    input  logic      rst_n,
    input  logic      init_ack_i,
    output logic      lcd_rst_o,
    output logic      init_stb_o,
    output lcd_rs_e   init_rs_o,
    output lcd_word_t init_data_o,
    output logic      init_done_o
);

    `include "lcd_init_table.svh"

    typedef enum logic [2:0] {
        S_RST_HOLD,
        S_RST_WAIT,
        S_SEND,
        S_WAIT_ACK,
        S_DONE
    } seq_state_e;

    localparam int CNT_MAX = (RST_HOLD > RST_WAIT) ? RST_HOLD : RST_WAIT;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);
    localparam int IDX_W   = $clog2(INIT_LEN + 1);

    seq_state_e       state;
    logic [CNT_W-1:0] cnt;  // shared by the hold and wait phases
    logic [IDX_W-1:0] idx;
    logic [16:0]      entry;

    assign entry       = init_table[idx];
    assign init_stb_o  = (state == S_SEND);  // one cycle per word
    assign init_rs_o   = lcd_rs_e'(entry[16]);
    assign init_data_o = entry[15:0];
    assign init_done_o = (state == S_DONE);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state     <= S_RST_HOLD;
            cnt       <= '0;
            idx       <= '0;
            lcd_rst_o <= PANEL_RST_ASSERT;
        end else begin
            case (state)
                S_RST_HOLD: begin
                    if (cnt == CNT_W'(RST_HOLD - 1)) begin
                        cnt       <= '0;
                        lcd_rst_o <= PANEL_RST_RELEASE;
                        state     <= S_RST_WAIT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_RST_WAIT: begin
                    if (cnt == CNT_W'(RST_WAIT - 1)) begin
                        cnt   <= '0;
                        state <= S_SEND;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_SEND: state <= S_WAIT_ACK;
                S_WAIT_ACK: begin
                    if (init_ack_i) begin
                        if (idx == IDX_W'(INIT_LEN - 1)) begin
                            state <= S_DONE;  // table exhausted
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= S_SEND;
                        end
                    end
                end
                default: state <= S_DONE;  // done is terminal
            endcase
        end
    end

    // the writer only answers a word this block has strobed
    a_ack_only_when_waiting: assert property (
        @(posedge pclk) disable iff (!rst_n)
        init_ack_i |-> (state == S_WAIT_ACK)
    ) else $error("init ack outside wait-ack");

endmodule

//--- design/lcd_cmd_pkg.sv
// drawing command package with host opcodes, panel commands and screen geometry
package lcd_cmd_pkg;

    // host opcodes, one strobe each
    typedef enum logic [1:0] {
        OP_FILL_RECT = 2'd0,  // fill x0..x1, y0..y1 with one colour
        OP_BL_ON     = 2'd1,
        OP_BL_OFF    = 2'd2
    } host_op_e;

    // pixel coordinate, wide enough for the long side
    typedef logic [9:0] coord_t;

    // panel geometry in portrait orientation
    localparam int SCREEN_W = 480;
    localparam int SCREEN_H = 800;

    // pixel count of the largest rectangle, 480 * 800 fits in 19 bits
    typedef logic [18:0] pix_cnt_t;

    // panel command codes as they go on the 16-bit bus
    localparam logic [15:0] CMD_COL_SET   = 16'h002A;  // column window
    localparam logic [15:0] CMD_PAGE_SET  = 16'h002B;  // page (row) window
    localparam logic [15:0] CMD_MEM_WRITE = 16'h002C;  // start of pixel stream

    // header of a fill
    // col cmd, x0 hi, x0 lo, x1 hi, x1 lo,
    // page cmd, y0 hi, y0 lo, y1 hi, y1 lo, mem write
    localparam int FILL_HDR_LEN = 11;

    // positions of the three commands within the header
    localparam int HDR_COL_IDX  = 0;
    localparam int HDR_PAGE_IDX = 5;
    localparam int HDR_MEM_IDX  = 10;

endpackage

//--- design/lcd_bus_pkg.sv
// panel bus package with the data word, the rs flag and the bus writer states
package lcd_bus_pkg;

    // one word on the 16-bit 8080 data pins
    typedef logic [15:0] lcd_word_t;

    // register select pin
    typedef enum logic {
        RS_CMD  = 1'b0,  // command / register address
        RS_DATA = 1'b1   // parameter or pixel data
    } lcd_rs_e;

    // write cycle shaping in the bus writer
    //   idle    cs high, wr high, waiting for a strobe
    //   wr_low  cs low, wr low, data being set up
    //   wr_high cs low, wr high, panel latches on the rising wr edge
    typedef enum logic [1:0] {
        BUS_IDLE    = 2'd0,
        BUS_WR_LOW  = 2'd1,
        BUS_WR_HIGH = 2'd2
    } bus_state_e;

    // drive levels of the active low strobes
    localparam logic STROBE_ON  = 1'b0;
    localparam logic STROBE_OFF = 1'b1;

    // panel reset pin levels
    localparam logic PANEL_RST_ASSERT  = 1'b0;
    localparam logic PANEL_RST_RELEASE = 1'b1;

    // a word the bus ignores, put out while nothing is pending
    localparam lcd_word_t LCD_WORD_IDLE = 16'h0000;

endpackage

//--- design/lcd_init_table.svh
// panel initialisation word table with its length
`ifndef LCD_INIT_TABLE_SVH
`define LCD_INIT_TABLE_SVH

localparam int INIT_LEN = 14;

// bit 16 is the rs flag (1 for data), bits 15:0 go on the pins
localparam logic [16:0] init_table [INIT_LEN] = '{
    {1'b0, 16'h0001},  // software reset
    {1'b0, 16'h0011},  // sleep out
    {1'b0, 16'h003A},  // pixel format
    {1'b1, 16'h0055},  // 16 bpp, rgb565
    {1'b0, 16'h0036},  // memory access control
    {1'b1, 16'h0000},  // portrait, rgb order
    {1'b0, 16'h00B1},  // frame rate control
    {1'b1, 16'h0000},
    {1'b1, 16'h0018},
    {1'b0, 16'h0035},  // tearing effect line on
    {1'b1, 16'h0000},
    {1'b0, 16'h0013},  // normal display mode
    {1'b0, 16'h0020},  // inversion off
    {1'b0, 16'h0029}   // display on
};

`endif
